// ==== source/uart_bridge_pkg.sv ====
package uart_bridge_pkg;

    // ******************************
    // Bit timing
    // ******************************
    localparam int CLKS_PER_BIT  = 16;   // Kept short for simulation
    localparam int IDLE_GAP_BITS = 20;   // Idle bit times that close an rx frame

    localparam int CLK_CNT_W     = $clog2(CLKS_PER_BIT);
    localparam int IDLE_GAP_CLKS = IDLE_GAP_BITS * CLKS_PER_BIT;
    localparam int GAP_CNT_W     = $clog2(IDLE_GAP_CLKS);

    // ******************************
    // Frame sizes
    // ******************************
    localparam int RX_FRAME_BITS    = 64;
    localparam int RX_PAYLOAD_BYTES = RX_FRAME_BITS / 8 - 3;  // Less len, rx_id, tx_ack
    localparam int TX_FRAME_BITS    = 64;
    localparam int TX_PAYLOAD_BYTES = TX_FRAME_BITS / 8 - 2;  // Less len, id

    // One event from the serial receiver
    typedef struct packed {
        logic [7:0] data;
        logic       valid;   // Byte strobe
        logic       eop;     // End of frame strobe
    } rx_byte_t;

    // Word published towards the host
    typedef struct packed {
        logic [RX_PAYLOAD_BYTES*8-1:0] payload;  // Last byte received in bits 7:0
        logic [7:0]                    len;
        logic [7:0]                    rx_id;
        logic [7:0]                    tx_ack;
    } rx_frame_t;

    // Word presented by the host
    typedef struct packed {
        logic [TX_PAYLOAD_BYTES*8-1:0] payload;  // Byte 0 is the lowest and goes out first
        logic [7:0]                    len;
        logic [7:0]                    id;
    } tx_frame_t;

endpackage

// ==== source/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      rx,
    output uart_bridge_pkg::rx_byte_t rx_byte
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t                              state;
    logic                                   rx_meta;
    logic                                   rx_sync;
    logic [uart_bridge_pkg::CLK_CNT_W-1:0]  clk_cnt;
    logic [2:0]                             bit_idx;
    logic [7:0]                             shift_reg;
    logic                                   valid_q;
    logic                                   eop_q;
    logic [uart_bridge_pkg::GAP_CNT_W-1:0]  gap_cnt;
    logic                                   gap_armed;  // Byte seen since last eop
    logic                                   bit_end;

    assign bit_end = (clk_cnt == uart_bridge_pkg::CLKS_PER_BIT - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // ******************************
    // Character FSM
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= RX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync) state <= RX_START;   // Falling edge of start bit
                end
                RX_START: begin
                    if (clk_cnt == uart_bridge_pkg::CLKS_PER_BIT / 2 - 1) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;  // Glitch goes back
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end
                end
                default: begin
                    if (bit_end) begin
                        valid_q <= rx_sync;   // Framing error drops the byte
                        state   <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end) shift_reg <= {rx_sync, shift_reg[7:1]};
    end

    // Idle gap after the last good byte ends the frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gap_cnt   <= '0;
            gap_armed <= 1'b0;
            eop_q     <= 1'b0;
        end else begin
            eop_q <= 1'b0;
            if (valid_q) gap_armed <= 1'b1;
            if (state != RX_IDLE || !rx_sync) begin
                gap_cnt <= '0;
            end else if (gap_armed) begin
                if (gap_cnt == uart_bridge_pkg::IDLE_GAP_CLKS - 1) begin
                    gap_cnt   <= '0;
                    gap_armed <= 1'b0;
                    eop_q     <= 1'b1;
                end else begin
                    gap_cnt <= gap_cnt + 1'b1;
                end
            end
        end
    end

    assign rx_byte.data  = shift_reg;
    assign rx_byte.valid = valid_q;
    assign rx_byte.eop   = eop_q;

endmodule

// ==== source/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] tx_byte,
    input  logic       tx_start,
    output logic       tx_busy,
    output logic       tx
);

    logic [9:0]                            shift_reg;  // Stop, data, start
    logic [uart_bridge_pkg::CLK_CNT_W-1:0] clk_cnt;
    logic [3:0]                            bit_cnt;

    // ******************************
    // 8N1 serialiser
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_reg <= '1;   // Line idles high
            clk_cnt   <= '0;
            bit_cnt   <= '0;
            tx_busy   <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                shift_reg <= {1'b1, tx_byte, 1'b0};
                clk_cnt   <= '0;
                bit_cnt   <= '0;
                tx_busy   <= 1'b1;
            end
        end else begin
            if (clk_cnt == uart_bridge_pkg::CLKS_PER_BIT - 1) begin
                clk_cnt   <= '0;
                shift_reg <= {1'b1, shift_reg[9:1]};  // Refill with idle level
                if (bit_cnt == 4'd9) begin
                    tx_busy <= 1'b0;   // Stop bit complete
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    assign tx = shift_reg[0];

endmodule

// ==== source/rx_frame_assembler.sv ====
`timescale 1ns/1ps

module rx_frame_assembler (
    input  logic                       clk,
    input  logic                       rst_n,
    input  uart_bridge_pkg::rx_byte_t  rx_byte,
    input  logic [7:0]                 tx_ack,
    output uart_bridge_pkg::rx_frame_t rxdata
);

    logic [uart_bridge_pkg::RX_PAYLOAD_BYTES*8-1:0] payload_buf;
    logic [7:0]                                     byte_cnt;
    logic [7:0]                                     frame_cnt;   // Wraps at 256

    // ******************************
    // Collect and publish
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            payload_buf <= '0;
            byte_cnt    <= '0;
            frame_cnt   <= '0;
            rxdata      <= '0;
        end else if (rx_byte.eop) begin
            rxdata.payload <= payload_buf;
            rxdata.len     <= byte_cnt;
            rxdata.rx_id   <= frame_cnt;
            rxdata.tx_ack  <= tx_ack;
            payload_buf    <= '0;
            byte_cnt       <= '0;
            frame_cnt      <= frame_cnt + 1'b1;
        end else if (rx_byte.valid) begin
            // Newest byte enters at the bottom and overflow is dropped
            if (byte_cnt < uart_bridge_pkg::RX_PAYLOAD_BYTES) begin
                payload_buf <= {payload_buf[uart_bridge_pkg::RX_PAYLOAD_BYTES*8-9:0],
                                rx_byte.data};
                byte_cnt    <= byte_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== source/tx_frame_sequencer.sv ====
`timescale 1ns/1ps

module tx_frame_sequencer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  uart_bridge_pkg::tx_frame_t txdata,
    input  logic                       tx_busy,
    output logic [7:0]                 tx_byte,
    output logic                       tx_start,
    output logic [7:0]                 tx_ack
);

    logic [uart_bridge_pkg::TX_PAYLOAD_BYTES*8-1:0] payload_buf;
    logic [7:0]                                     bytes_left;
    logic [7:0]                                     last_id;
    logic [7:0]                                     len_clamped;
    logic                                           sending;
    logic                                           new_frame;

    assign new_frame = !sending && (txdata.id != last_id);

    // Longer frames are cut to the payload capacity
    assign len_clamped = (txdata.len > uart_bridge_pkg::TX_PAYLOAD_BYTES) ?
                         8'(uart_bridge_pkg::TX_PAYLOAD_BYTES) : txdata.len;

    // ******************************
    // Frame control
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sending    <= 1'b0;
            bytes_left <= '0;
            last_id    <= '0;
            tx_start   <= 1'b0;
            tx_ack     <= '0;
        end else begin
            tx_start <= 1'b0;
            if (new_frame) begin
                last_id    <= txdata.id;
                bytes_left <= len_clamped;
                sending    <= 1'b1;
            end else if (sending && !tx_busy && !tx_start) begin
                if (bytes_left != 8'd0) begin
                    tx_start   <= 1'b1;
                    bytes_left <= bytes_left - 1'b1;
                end else begin
                    tx_ack  <= last_id;   // Last stop bit is out
                    sending <= 1'b0;
                end
            end
        end
    end

    // Payload path, byte 0 first
    always_ff @(posedge clk) begin
        if (new_frame) begin
            payload_buf <= txdata.payload;
        end else if (sending && !tx_busy && !tx_start && bytes_left != 8'd0) begin
            tx_byte     <= payload_buf[7:0];
            payload_buf <= payload_buf >> 8;
        end
    end

endmodule

// ==== source/uart_bridge.sv ====
`timescale 1ns/1ps

module uart_bridge (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       rx,
    output logic                       tx,
    input  uart_bridge_pkg::tx_frame_t txdata,
    output uart_bridge_pkg::rx_frame_t rxdata
);

    uart_bridge_pkg::rx_byte_t rx_byte;
    logic [7:0]                tx_ack;
    logic [7:0]                tx_byte;
    logic                      tx_start;
    logic                      tx_busy;

    // ******************************
    // Receive chain
    // ******************************
    uart_rx u_uart_rx (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx      (rx),
        .rx_byte (rx_byte)
    );

    rx_frame_assembler u_rx_frame_assembler (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx_byte (rx_byte),
        .tx_ack  (tx_ack),     // Ack rides back on the next rx frame
        .rxdata  (rxdata)
    );

    // ******************************
    // Transmit chain
    // ******************************
    tx_frame_sequencer u_tx_frame_sequencer (
        .clk      (clk),
        .rst_n    (rst_n),
        .txdata   (txdata),
        .tx_busy  (tx_busy),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .tx_ack   (tx_ack)
    );

    uart_tx u_uart_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .tx       (tx)
    );

endmodule

// ==== bench/uart_bridge_checker.sv ====
`timescale 1ns/1ps

module uart_bridge_checker (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      tx_start,
    input logic                      tx_busy,
    input logic                      tx,
    input uart_bridge_pkg::rx_byte_t rx_byte
);

    int fail_count = 0;   // Read by the testbench at the end of the run

    // ******************************
    // Transmit handshake and line
    // ******************************
    a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        tx_start |-> !tx_busy)
        else begin $error("tx_start raised while tx_busy is high"); fail_count++; end

    a_line_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        !tx_busy |-> tx)
        else begin $error("tx low while uart_tx is not busy"); fail_count++; end

    a_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        tx_start |=> !tx_start)
        else begin $error("tx_start held for more than one cycle"); fail_count++; end

    // ******************************
    // Receive strobes
    // ******************************
    a_strobes_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(rx_byte.valid && rx_byte.eop))
        else begin $error("valid and eop strobes high together"); fail_count++; end

    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        rx_byte.valid |=> !rx_byte.valid)
        else begin $error("valid strobe held for more than one cycle"); fail_count++; end

    a_eop_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        rx_byte.eop |=> !rx_byte.eop)
        else begin $error("eop strobe held for more than one cycle"); fail_count++; end

endmodule

bind uart_bridge uart_bridge_checker u_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .tx       (tx),
    .rx_byte  (rx_byte)
);

// ==== bench/uart_bridge_tb.sv ====
`timescale 1ns/1ps

module uart_bridge_tb;

    localparam int NUM_ENTRIES  = 5;
    localparam int MAX_RX_BYTES = 7;
    localparam int WATCHDOG_NS  = 2 * (NUM_ENTRIES * (MAX_RX_BYTES +
        uart_bridge_pkg::TX_PAYLOAD_BYTES) * 10 * uart_bridge_pkg::CLKS_PER_BIT * 20 +
        NUM_ENTRIES * uart_bridge_pkg::IDLE_GAP_BITS * uart_bridge_pkg::CLKS_PER_BIT * 20);

    typedef struct packed {
        uart_bridge_pkg::tx_frame_t tx;
        logic [MAX_RX_BYTES*8-1:0]  rx_bytes;   // Byte 0 in the low bits, sent first
        logic [3:0]                 rx_cnt;
        logic [7:0]                 exp_tx_cnt;
        logic [7:0]                 exp_len;
        logic [7:0]                 exp_rx_id;
        logic [7:0]                 exp_ack;
    } entry_t;

    logic                       clk;
    logic                       rst_n;
    logic                       rx;
    logic                       tx;
    uart_bridge_pkg::tx_frame_t txdata;
    uart_bridge_pkg::rx_frame_t rxdata;

    entry_t     stim_table [NUM_ENTRIES];
    logic [7:0] tx_bytes [$];      // Bytes decoded from the tx line
    logic [7:0] lfsr_state = 8'd31;
    int         errors = 0;
    int         checks = 0;

    uart_bridge u_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .rx     (rx),
        .tx     (tx),
        .txdata (txdata),
        .rxdata (rxdata)
    );

    always #10 clk = ~clk;

    // ******************************
    // Stimulus helpers
    // ******************************
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);   // x^8 + x^6 + x^5 + x^4 + 1
    endfunction

    task automatic get_rand_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b[i] = lfsr_state[0];
        end
    endtask

    task automatic set_entry(input int idx, input logic [7:0] id, input logic [7:0] len,
                             input logic [47:0] payload, input logic [3:0] rx_cnt,
                             input logic [55:0] rx_bytes, input logic [7:0] exp_tx_cnt,
                             input logic [7:0] exp_len, input logic [7:0] exp_rx_id,
                             input logic [7:0] exp_ack);
        stim_table[idx] = '{tx: '{payload: payload, len: len, id: id},
                            rx_bytes: rx_bytes, rx_cnt: rx_cnt, exp_tx_cnt: exp_tx_cnt,
                            exp_len: exp_len, exp_rx_id: exp_rx_id, exp_ack: exp_ack};
    endtask

    // Serial driver steps one bit every CLKS_PER_BIT falling edges
    task automatic send_rx_byte(input logic [7:0] b);
        logic [9:0] char_bits;
        char_bits = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx = char_bits[i];
            repeat (uart_bridge_pkg::CLKS_PER_BIT) @(negedge clk);
        end
    endtask

    // Newest kept byte lands at the bottom and overflow beyond capacity is lost
    function automatic logic [39:0] expected_rx_payload(input entry_t e);
        logic [39:0] p;
        int          n;
        p = '0;
        n = (e.rx_cnt > uart_bridge_pkg::RX_PAYLOAD_BYTES) ?
            uart_bridge_pkg::RX_PAYLOAD_BYTES : e.rx_cnt;
        for (int k = 0; k < n; k++) p = (p << 8) | 40'(e.rx_bytes[8*k +: 8]);
        return p;
    endfunction

    task automatic wait_tx_bytes(input int n);
        int cycles;
        cycles = 0;
        while (tx_bytes.size() < n && cycles < 80 * uart_bridge_pkg::CLKS_PER_BIT) begin
            @(negedge clk);
            cycles++;
        end
        if (tx_bytes.size() < n) begin
            errors++;
            $display("Timed out at %0t waiting for %0d bytes on tx", $time, n);
        end
    endtask

    task automatic wait_ack(input logic [7:0] id);
        int cycles;
        cycles = 0;
        while (u_dut.tx_ack !== id && cycles < 4 * uart_bridge_pkg::CLKS_PER_BIT) begin
            @(negedge clk);
            cycles++;
        end
        if (u_dut.tx_ack !== id) begin
            errors++;
            $display("Timed out at %0t waiting for the ack of id %0d", $time, id);
        end
    endtask

    task automatic wait_rxdata_change(input uart_bridge_pkg::rx_frame_t prev);
        int cycles;
        cycles = 0;
        while (rxdata === prev &&
               cycles < (uart_bridge_pkg::IDLE_GAP_BITS + 4) * uart_bridge_pkg::CLKS_PER_BIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (rxdata === prev) begin
            errors++;
            $display("Timed out at %0t waiting for a new rxdata word", $time);
        end
    endtask

    // ******************************
    // Serial monitor on tx
    // ******************************
    initial begin
        logic [7:0] b;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            if (tx === 1'b0) begin
                repeat (uart_bridge_pkg::CLKS_PER_BIT / 2) @(negedge clk);
                if (tx !== 1'b0) begin
                    errors++;
                    $display("CHECK FAILED %0t: start bit on tx not low at mid-bit", $time);
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (uart_bridge_pkg::CLKS_PER_BIT) @(negedge clk);
                    b[i] = tx;
                end
                repeat (uart_bridge_pkg::CLKS_PER_BIT) @(negedge clk);
                if (tx !== 1'b1) begin
                    errors++;
                    $display("CHECK FAILED %0t: stop bit on tx not high", $time);
                end
                tx_bytes.push_back(b);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Simulation timed out after %0d ns", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

    // ******************************
    // Main sequence
    // ******************************
    initial begin
        entry_t                     e;
        uart_bridge_pkg::rx_frame_t prev;
        logic [7:0]                 b;
        clk    = 1'b0;
        rst_n  = 1'b0;
        rx     = 1'b1;
        txdata = '0;

        set_entry(0, 8'd1, 8'd3, 48'h0000_00C3_B2A1, 4'd2, 56'h2211, 8'd3, 8'd2, 8'd0, 8'd1);
        set_entry(1, 8'd2, 8'd7, 48'h0, 4'd5, 56'h7E_81FF_005A, 8'd6, 8'd5, 8'd1, 8'd2);
        set_entry(2, 8'd2, 8'd4, 48'hDEAD_BEEF_0102, 4'd7, 56'h07_0605_0403_0201,
                  8'd0, 8'd5, 8'd2, 8'd2);    // Same id again, nothing goes out
        set_entry(3, 8'd3, 8'd0, 48'h1234_5678_9ABC, 4'd1, 56'h96, 8'd0, 8'd1, 8'd3, 8'd3);
        set_entry(4, 8'd4, 8'd1, 48'h0, 4'd3, 56'h0, 8'd1, 8'd3, 8'd4, 8'd4);
        for (int j = 0; j < 6; j++) begin
            get_rand_byte(b);
            stim_table[1].tx.payload[8*j +: 8] = b;
        end
        for (int j = 0; j < 6; j++) begin
            get_rand_byte(b);
            stim_table[4].tx.payload[8*j +: 8] = b;
        end
        for (int j = 0; j < 3; j++) begin
            get_rand_byte(b);
            stim_table[4].rx_bytes[8*j +: 8] = b;
        end

        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        for (int c = 0; c < 10; c++) begin
            @(negedge clk);
            checks++;
            if (tx !== 1'b1 || rxdata !== '0) begin
                errors++;
                $display("CHECK FAILED %0t: reset state tx=%b rxdata=%h", $time, tx, rxdata);
            end
        end

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            e = stim_table[i];
            txdata = e.tx;
            wait_tx_bytes(e.exp_tx_cnt);
            wait_ack(e.exp_ack);
            if (i == 0) begin
                checks++;
                if (rxdata !== '0) begin
                    errors++;
                    $display("CHECK FAILED %0t: rxdata %h before first frame", $time, rxdata);
                end
            end
            prev = rxdata;
            for (int k = 0; k < e.rx_cnt; k++) send_rx_byte(e.rx_bytes[8*k +: 8]);
            wait_rxdata_change(prev);

            checks++;
            if (tx_bytes.size() != e.exp_tx_cnt) begin
                errors++;
                $display("CHECK FAILED %0t: entry %0d sent %0d bytes on tx, expected %0d",
                         $time, i, tx_bytes.size(), e.exp_tx_cnt);
            end
            for (int j = 0; j < tx_bytes.size() && j < e.exp_tx_cnt; j++) begin
                checks++;
                if (tx_bytes[j] !== e.tx.payload[8*j +: 8]) begin
                    errors++;
                    $display("CHECK FAILED %0t: entry %0d tx byte %0d got %h expected %h",
                             $time, i, j, tx_bytes[j], e.tx.payload[8*j +: 8]);
                end
            end
            tx_bytes.delete();

            checks++;
            if (rxdata.payload !== expected_rx_payload(e) || rxdata.len !== e.exp_len) begin
                errors++;
                $display("CHECK FAILED %0t: entry %0d rx payload %h len %0d, expected %h len %0d",
                         $time, i, rxdata.payload, rxdata.len, expected_rx_payload(e),
                         e.exp_len);
            end
            checks++;
            if (rxdata.rx_id !== e.exp_rx_id || rxdata.tx_ack !== e.exp_ack) begin
                errors++;
                $display("CHECK FAILED %0t: entry %0d rx_id %0d tx_ack %0d, expected %0d %0d",
                         $time, i, rxdata.rx_id, rxdata.tx_ack, e.exp_rx_id, e.exp_ack);
            end
        end

        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, u_dut.u_checker.fail_count);
        if (errors == 0 && u_dut.u_checker.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
source/uart_bridge_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/rx_frame_assembler.sv
source/tx_frame_sequencer.sv
source/uart_bridge.sv
bench/uart_bridge_checker.sv
bench/uart_bridge_tb.sv
